//--- common/zports_defs.svh
/*
 * low address byte of each internal port and the idle bus value,
 * included by the decoder, the read mux and the testbench
 */
`ifndef ZPORTS_DEFS_SVH
`define ZPORTS_DEFS_SVH

////////////////////////////////////////
// port numbers, low address byte
////////////////////////////////////////

`define ZP_PORT_FE     8'hFE // alu operand hi byte
`define ZP_PORT_F6     8'hF6 // alu operand lo byte
`define ZP_PORT_FD     8'hFD // 7FFD paging, FFFD/BFFD go to the sound chip
`define ZP_PORT_F7     8'hF7 // EFF7 paging

// input devices
`define ZP_PORT_KJOY   8'h1F // joystick, normal mode only
`define ZP_PORT_MOUSE  8'hDF // mouse

// sd card, z-controller layout
`define ZP_PORT_SDCFG  8'h77 // chip select, normal mode only
`define ZP_PORT_SDDAT  8'h57 // data, also cfg in shadow with a15 set

// evo config
`define ZP_PORT_ZXBF   8'hBF // shadow enable, rom write enable
`define ZP_PORT_ZXBE   8'hBE // readback by a[11:8]

////////////////////////////////////////
// bus values
////////////////////////////////////////

// pulled-up bus, read from any unmapped port
`define ZP_IDLE_BYTE   8'hFF

`endif

//--- common/zports_pkg.sv
/*
 * shared types of the I/O port block: data byte, pager readback vector
 * and the port select produced by the address decoder
 */
package zports_pkg;

	// one Z80 data byte
	typedef logic [7:0] byte_t;

	// eight page bytes from the memory pager, byte 0 in bits 7..0
	typedef logic [63:0] pages_t;

	////////////////////////////////////////
	// port select
	////////////////////////////////////////

	// which internal port the low address byte hits,
	// already filtered by the shadow rules
	typedef enum logic [3:0] {
		ps_none  = 4'd0,  // no internal port
		ps_fe    = 4'd1,  // operand hi / alu_src
		ps_f6    = 4'd2,  // operand lo / alu_arg
		ps_fd    = 4'd3,  // 7FFD family
		ps_f7    = 4'd4,  // EFF7 family
		ps_kjoy  = 4'd5,  // kempston joystick
		ps_mouse = 4'd6,  // kempston mouse
		ps_sdcfg = 4'd7,  // sd config
		ps_sddat = 4'd8,  // sd data
		ps_zxbf  = 4'd9,  // config flags
		ps_zxbe  = 4'd10  // config readback
	} port_sel_e;

endpackage

//--- src/io_strobe.sv
/*
 * one-cycle write and read pulses from the Z80 I/O strobes,
 * one pulse per bus cycle on its leading edge
 */
module io_strobe
(
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic iowr_now; // write cycle active
	logic iord_now;
	logic iowr_reg; // level seen on the last edge
	logic iord_reg;

	assign iowr_now = ~(iorq_n | wr_n);
	assign iord_now = ~(iorq_n | rd_n);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			iowr_reg <= iowr_now;
			iord_reg <= iord_now;
			port_wr  <= iowr_now & ~iowr_reg; // rising edge of the write cycle
			port_rd  <= iord_now & ~iord_reg;
		end
	end

endmodule

//--- src/port_decode.sv
/*
 * low address byte decode into a port select, with the shadow rules;
 * also drives porthit for the bus and the Z80 data drive enable
 */
`include "zports_defs.svh"

module port_decode
(
	input  logic [15:0]              a,
	input  logic                     iorq_n,
	input  logic                     rd_n,
	input  logic                     shadow,
	output zports_pkg::port_sel_e    port_sel,
	output logic                     porthit,
	output logic                     dataout
);

	zports_pkg::byte_t loa; // low address byte
	logic external_port;    // hit, but another chip drives the data

	assign loa = a[7:0];

	////////////////////////////////////////
	// port table
	////////////////////////////////////////

	always_comb
	begin
		port_sel = zports_pkg::ps_none;
		case (loa)
			`ZP_PORT_FE:
				port_sel = zports_pkg::ps_fe;
			`ZP_PORT_F6:
				port_sel = zports_pkg::ps_f6;
			`ZP_PORT_FD:
				port_sel = zports_pkg::ps_fd;
			`ZP_PORT_F7:
				// xEF7 outside shadow, xEE7 style (a8 clear) inside
				if (a[8] != shadow)
					port_sel = zports_pkg::ps_f7;
			`ZP_PORT_KJOY:
				if (!shadow) // 1F belongs to the fdc in shadow mode
					port_sel = zports_pkg::ps_kjoy;
			`ZP_PORT_MOUSE:
				port_sel = zports_pkg::ps_mouse;
			`ZP_PORT_SDCFG:
				if (!shadow)
					port_sel = zports_pkg::ps_sdcfg;
			`ZP_PORT_SDDAT:
				port_sel = zports_pkg::ps_sddat; // both modes
			`ZP_PORT_ZXBF:
				port_sel = zports_pkg::ps_zxbf;
			`ZP_PORT_ZXBE:
				port_sel = zports_pkg::ps_zxbe;
			default:
				port_sel = zports_pkg::ps_none;
		endcase
	end

	assign porthit = (port_sel != zports_pkg::ps_none);

	// FFFD is read from the sound chip, not from us
	assign external_port = (port_sel == zports_pkg::ps_fd) && (a[15:14] == 2'b11);

	// drive the Z80 bus only during a read of our own port
	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

endmodule

//--- paging/paging_regs.sv
/*
 * 7FFD and EFF7 paging registers with the 48K and 1-meg locks;
 * raw values go to readback, masked values to the pager
 */
module paging_regs
(
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic [15:0]           a,
	input  zports_pkg::byte_t     din,
	input  logic                  shadow,
	input  zports_pkg::port_sel_e port_sel,
	input  logic                  port_wr,
	output zports_pkg::byte_t     p7ffd,
	output zports_pkg::byte_t     peff7,
	output zports_pkg::byte_t     p7ffd_raw,
	output zports_pkg::byte_t     peff7_raw,
	output logic [5:0]            pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0
);

	logic block1m;   // eff7 bit 2, 128K-compatible mode
	logic block7ffd; // 48K lock
	logic p7ffd_wr;
	logic peff7_wr;

	assign block1m   = peff7_raw[2];
	assign block7ffd = p7ffd_raw[5] & block1m;

	// 7FFD: a15 must be clear, FFFD/BFFD are the sound chip
	assign p7ffd_wr = port_wr && (port_sel == zports_pkg::ps_fd) && !a[15] && !block7ffd;

	// EFF7: never in shadow mode, a12 clear
	assign peff7_wr = port_wr && (port_sel == zports_pkg::ps_f7) && !shadow && !a[12];

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_raw <= 8'h00; // rom bit too
			peff7_raw <= 8'h00;
		end
		else
		begin
			if (p7ffd_wr)
				p7ffd_raw <= din; // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 1M page
			if (peff7_wr)
				peff7_raw <= din; // 2 block1m, 3 ram0 at 0000
		end
	end

	////////////////////////////////////////
	// masked outputs
	////////////////////////////////////////

	assign p7ffd = block1m ? {3'b000, p7ffd_raw[4:0]} : p7ffd_raw; // no hi page bits
	assign peff7 = block1m ?
		{peff7_raw[7], 1'b0, peff7_raw[5:4], 3'b000, peff7_raw[0]} : peff7_raw;

	assign pent1m_rom    = p7ffd_raw[4];
	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]}; // full 1M page
	assign pent1m_1m_on  = ~peff7_raw[2];
	assign pent1m_ram0_0 = peff7_raw[3];

endmodule

//--- src/sd_ctrl.sv
/*
 * sd card port logic: chip select register, one-cycle spi start
 * and the byte handed to the spi shifter
 */
module sd_ctrl
(
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic [15:0]           a,
	input  zports_pkg::byte_t     din,
	input  logic                  wr_n,
	input  logic                  shadow,
	input  zports_pkg::port_sel_e port_sel,
	input  logic                  port_wr,
	input  logic                  port_rd,
	output logic                  sdcs_n,
	output logic                  sd_start,
	output zports_pkg::byte_t     sd_datain
);

	logic cfg_wr;  // chip select write
	logic dat_acc; // any data access, kicks the shifter
	logic is_dat;
	logic dat_cfg; // 57 acting as cfg, shadow with a15 set

	assign is_dat  = (port_sel == zports_pkg::ps_sddat);
	assign dat_cfg = is_dat && shadow && a[15];

	assign cfg_wr  = port_wr && ((port_sel == zports_pkg::ps_sdcfg) || dat_cfg);
	assign dat_acc = (port_wr && is_dat && !dat_cfg) || (port_rd && is_dat);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sdcs_n   <= 1'b1; // card deselected
			sd_start <= 1'b0;
		end
		else
		begin
			if (cfg_wr)
				sdcs_n <= din[1];
			sd_start <= dat_acc; // one cycle after the port pulse
		end
	end

	// reads shift out all ones
	assign sd_datain = wr_n ? 8'hFF : din;

endmodule

//--- src/config_regs.sv
/*
 * port BF flags (shadow enable, rom write enable), the resulting
 * shadow mode, and the FE/F6 operand registers of the alu
 */
module config_regs
(
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic [15:0]           a,
	input  zports_pkg::byte_t     din,
	input  logic                  dos,
	input  zports_pkg::port_sel_e port_sel,
	input  logic                  port_wr,
	output logic                  shadow,
	output logic                  romrw_en,
	output zports_pkg::byte_t     cfg_flags,
	output logic [15:0]           alu_src,
	output logic [15:0]           alu_arg
);

	logic shadow_en; // bf bit 0

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			alu_src   <= 16'h0000;
			alu_arg   <= 16'h0000;
		end
		else if (port_wr)
		begin
			// only one select can be active per pulse
			if (port_sel == zports_pkg::ps_zxbf)
			begin
				shadow_en <= din[0];
				romrw_en  <= din[1];
			end
			if (port_sel == zports_pkg::ps_fe)
				alu_src <= {a[15:8], din}; // hi byte rides on the address
			if (port_sel == zports_pkg::ps_f6)
				alu_arg <= {a[15:8], din};
		end
	end

	// shadow ports on in dos or by request
	assign shadow = dos | shadow_en;

	// readback layout of port BF
	assign cfg_flags = {6'b000000, romrw_en, shadow_en};

endmodule

//--- src/read_mux.sv
/*
 * byte driven to the Z80 on internal port reads,
 * selected by the decoded port; BE readback indexed by a[11:8]
 */
`include "zports_defs.svh"

module read_mux
(
	input  logic [15:0]           a,
	input  logic                  shadow,
	input  zports_pkg::port_sel_e port_sel,
	input  logic [15:0]           alu_in,
	input  logic [4:0]            kj_in,
	input  zports_pkg::byte_t     mus_in,
	input  zports_pkg::byte_t     sd_dataout,
	input  zports_pkg::byte_t     cfg_flags,
	input  zports_pkg::pages_t    pages,
	input  zports_pkg::byte_t     ramnroms,
	input  zports_pkg::byte_t     dos7ffds,
	input  zports_pkg::byte_t     p7ffd_raw,
	input  zports_pkg::byte_t     peff7_raw,
	output zports_pkg::byte_t     dout
);

	zports_pkg::byte_t be_mux; // port BE readback

	////////////////////////////////////////
	// BE readback
	////////////////////////////////////////

	always_comb
	begin
		case (a[11:8])
			4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7:
				be_mux = pages[{a[10:8], 3'b000} +: 8]; // pager windows
			4'h8:
				be_mux = ramnroms;
			4'h9:
				be_mux = dos7ffds;
			4'hA:
				be_mux = p7ffd_raw; // unmasked
			4'hB:
				be_mux = peff7_raw;
			default:
				be_mux = `ZP_IDLE_BYTE;
		endcase
	end

	always_comb
	begin
		case (port_sel)
			zports_pkg::ps_fe:
				dout = alu_in[15:8];
			zports_pkg::ps_f6:
				dout = alu_in[7:0];
			zports_pkg::ps_kjoy:
				dout = {3'b000, kj_in}; // zero fill
			zports_pkg::ps_mouse:
				dout = mus_in;
			zports_pkg::ps_sdcfg:
				dout = 8'h00; // card present, not write protected
			zports_pkg::ps_sddat:
				dout = sd_dataout;
			zports_pkg::ps_zxbf:
				dout = cfg_flags;
			zports_pkg::ps_zxbe:
				dout = be_mux;
			default:
				dout = `ZP_IDLE_BYTE;
		endcase
	end

endmodule

//--- src/zports_top.sv
/*
 * Z80 I/O port block top level: strobe pulses, decode,
 * config, paging and sd registers, read data mux
 */
module zports_top
(
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic [15:0]           a,
	input  zports_pkg::byte_t     din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  dos,
	input  logic [4:0]            kj_in,
	input  zports_pkg::byte_t     mus_in,
	input  zports_pkg::byte_t     sd_dataout,
	input  logic [15:0]           alu_in,
	input  zports_pkg::pages_t    pages,
	input  zports_pkg::byte_t     ramnroms,
	input  zports_pkg::byte_t     dos7ffds,
	output zports_pkg::byte_t     dout,
	output logic                  dataout,
	output logic                  porthit,
	output zports_pkg::byte_t     p7ffd,
	output zports_pkg::byte_t     peff7,
	output logic [5:0]            pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0,
	output logic                  romrw_en,
	output logic                  sdcs_n,
	output logic                  sd_start,
	output zports_pkg::byte_t     sd_datain,
	output logic [15:0]           alu_src,
	output logic [15:0]           alu_arg
);

	logic                  port_wr;   // one-cycle pulses
	logic                  port_rd;
	logic                  shadow;
	zports_pkg::port_sel_e port_sel;
	zports_pkg::byte_t     cfg_flags;
	zports_pkg::byte_t     p7ffd_raw; // for BE readback
	zports_pkg::byte_t     peff7_raw;

	io_strobe io_strobe_inst (.zclk, .rst_n, .iorq_n, .rd_n, .wr_n, .port_wr, .port_rd);

	port_decode port_decode_inst (.a, .iorq_n, .rd_n, .shadow, .port_sel, .porthit, .dataout);

	config_regs config_regs_inst (.zclk, .rst_n, .a, .din, .dos, .port_sel, .port_wr,
		.shadow, .romrw_en, .cfg_flags, .alu_src, .alu_arg);

	paging_regs paging_regs_inst (.zclk, .rst_n, .a, .din, .shadow, .port_sel, .port_wr,
		.p7ffd, .peff7, .p7ffd_raw, .peff7_raw,
		.pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0);

	sd_ctrl sd_ctrl_inst (.zclk, .rst_n, .a, .din, .wr_n, .shadow, .port_sel,
		.port_wr, .port_rd, .sdcs_n, .sd_start, .sd_datain);

	read_mux read_mux_inst (.a, .shadow, .port_sel, .alu_in, .kj_in, .mus_in, .sd_dataout,
		.cfg_flags, .pages, .ramnroms, .dos7ffds, .p7ffd_raw, .peff7_raw, .dout);

endmodule

//--- sim/zports_props.sv
/*
 * pulse and bus-drive properties of the port block,
 * attached to zports_top by the bind at the bottom
 */
module zports_props
(
	input logic zclk,
	input logic rst_n,
	input logic sd_start,
	input logic dataout,
	input logic porthit,
	input logic port_wr,
	input logic sdcs_n
);

	////////////////////////////////////////
	// pulses
	////////////////////////////////////////

	// spi kick lasts one cycle only
	sd_start_single: assert property (@(posedge zclk) disable iff (!rst_n)
		sd_start |=> !sd_start)
		else $error("sd_start stayed high for two cycles");

	port_wr_single: assert property (@(posedge zclk) disable iff (!rst_n)
		port_wr |=> !port_wr) // one load per bus cycle
		else $error("port_wr stayed high for two cycles");

	////////////////////////////////////////
	// bus drive and reset state
	////////////////////////////////////////

	// never drive the bus for a port we do not own
	dataout_needs_hit: assert property (@(posedge zclk) disable iff (!rst_n)
		dataout |-> porthit)
		else $error("dataout high without porthit");

	sdcs_after_reset: assert property (@(posedge zclk)
		$rose(rst_n) |-> sdcs_n) // card deselected
		else $error("sdcs_n low on the first cycle after reset");

endmodule

bind zports_top zports_props zports_props_inst (.zclk, .rst_n, .sd_start, .dataout,
	.porthit, .port_wr, .sdcs_n);

//--- sim/zports_tb.sv
/*
 * testbench of the I/O port block: replays the bus operations of
 * sim/zports_trace.txt against zports_top and checks the named outputs
 */
`include "zports_defs.svh"

module zports_tb;

	localparam int clk_period = 100;

	logic                  zclk;
	logic                  rst_n;
	logic [15:0]           a;
	zports_pkg::byte_t     din;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic                  dos;
	logic [4:0]            kj_in;
	zports_pkg::byte_t     mus_in;
	zports_pkg::byte_t     sd_dataout;
	logic [15:0]           alu_in;
	zports_pkg::pages_t    pages;
	zports_pkg::byte_t     ramnroms;
	zports_pkg::byte_t     dos7ffds;
	zports_pkg::byte_t     dout;
	logic                  dataout;
	logic                  porthit;
	zports_pkg::byte_t     p7ffd;
	zports_pkg::byte_t     peff7;
	logic [5:0]            pent1m_page;
	logic                  pent1m_rom;
	logic                  pent1m_1m_on;
	logic                  pent1m_ram0_0;
	logic                  romrw_en;
	logic                  sdcs_n;
	logic                  sd_start;
	zports_pkg::byte_t     sd_datain;
	logic [15:0]           alu_src;
	logic [15:0]           alu_arg;

	// trace columns
	string       op_q[$];
	logic [15:0] addr_q[$];
	logic [7:0]  data_q[$];
	logic [31:0] exp_q[$];
	string       key_q[$];
	int          n_ops;
	logic        trace_loaded;
	int          errors;
	int          n_checks;

	// sampled on the last low-strobe falling edge
	logic [7:0]  seen_dout;
	logic        seen_porthit;
	logic        seen_dataout;
	logic [7:0]  seen_sd_datain;
	logic [4:0]  start_mask; // bit k: sd_start after rising edge k+1

	// paging state left by the trace writes
	logic [7:0]  exp_7ffd;
	logic [7:0]  exp_eff7;
	logic        exp_shadow_en; // bf bit 0

	zports_top zports_top_inst (.*);

	always #(clk_period / 2) zclk = ~zclk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp_val);
		n_checks++;
		if (got !== exp_val)
		begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp_val);
		end
	endtask

	// values that come from the random inputs, by port
	function automatic logic [7:0] expected_random(input logic [15:0] addr);
		case (addr[7:0])
			`ZP_PORT_FE:    expected_random = alu_in[15:8];
			`ZP_PORT_F6:    expected_random = alu_in[7:0];
			`ZP_PORT_MOUSE: expected_random = mus_in;
			`ZP_PORT_ZXBE:  expected_random = 8'(pages >> (8 * addr[11:8])); // page n
			default:        expected_random = `ZP_IDLE_BYTE;
		endcase
	endfunction

	task automatic load_trace();
		int          fd;
		int          code;
		string       line;
		string       op;
		string       key;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] exp_val;
		fd = $fopen("sim/zports_trace.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("cannot open the trace file sim/zports_trace.txt");
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code == 0)
				break;
			if (line.len() < 2 || line[0] == "#")
				continue; // blank or column notes
			code = $sscanf(line, "%s %h %h %h %s", op, addr, data, exp_val, key);
			if (code != 5)
			begin
				errors++;
				$display("malformed trace line: %s", line);
				continue;
			end
			op_q.push_back(op);
			addr_q.push_back(addr);
			data_q.push_back(data);
			exp_q.push_back(exp_val);
			key_q.push_back(key);
		end
		$fclose(fd);
		n_ops = op_q.size();
	endtask

	////////////////////////////////////////
	// bus driver
	////////////////////////////////////////

	// entered on a falling edge: strobes low for 3 cycles, then 2 idle
	task automatic bus_cycle(input logic is_wr, input logic [15:0] addr,
		input logic [7:0] data);
		int k;
		a          = addr;
		din        = data;
		iorq_n     = 1'b0;
		rd_n       = is_wr;
		wr_n       = ~is_wr;
		start_mask = 5'b00000;
		for (k = 0; k < 5; k++)
		begin
			@(negedge zclk);
			start_mask[k] = sd_start;
			if (k == 2)
			begin
				seen_dout      = dout; // mid-cycle, all settled
				seen_porthit   = porthit;
				seen_dataout   = dataout;
				seen_sd_datain = sd_datain;
				iorq_n         = 1'b1;
				rd_n           = 1'b1;
				wr_n           = 1'b1;
			end
		end
	endtask

	task automatic check_named(input string key, input logic [15:0] addr,
		input logic [31:0] exp_val);
		case (key)
			"rnd":
			begin
				check_value("dout", 32'(seen_dout), 32'(expected_random(addr)));
				check_value("dataout", 32'(seen_dataout), 32'd1); // own port, driven
			end
			"dout":        check_value("dout", 32'(seen_dout), exp_val);
			"porthit":     check_value("porthit", 32'(seen_porthit), exp_val);
			"dataout":     check_value("dataout", 32'(seen_dataout), exp_val);
			"sd_datain":   check_value("sd_datain", 32'(seen_sd_datain), exp_val);
			"sd_start":    check_value("sd_start", 32'(start_mask), exp_val);
			"sdcs_n":      check_value("sdcs_n", 32'(sdcs_n), exp_val);
			"romrw_en":    check_value("romrw_en", 32'(romrw_en), exp_val);
			"alu_src":     check_value("alu_src", 32'(alu_src), exp_val);
			"alu_arg":     check_value("alu_arg", 32'(alu_arg), exp_val);
			"p7ffd":       check_value("p7ffd", 32'(p7ffd), exp_val);
			"peff7":       check_value("peff7", 32'(peff7), exp_val);
			"pent1m_page": check_value("pent1m_page", 32'(pent1m_page), exp_val);
			"-":           ; // no check
			default:
			begin
				errors++;
				$display("unknown output name %s in the trace", key);
			end
		endcase
	endtask

	// raw paging bytes after a write, then the pent1m flags derived from them
	task automatic follow_paging_write(input logic [15:0] addr, input logic [7:0] data);
		logic in_shadow;
		in_shadow = dos | exp_shadow_en;
		case (addr[7:0])
			`ZP_PORT_ZXBF:
				exp_shadow_en = data[0];
			`ZP_PORT_FD:
				if (!addr[15] && !(exp_7ffd[5] && exp_eff7[2])) // a15 clear, no 48K lock
					exp_7ffd = data;
			`ZP_PORT_F7:
				if (!in_shadow && addr[8] && !addr[12])
					exp_eff7 = data;
			default:
				;
		endcase
		check_value("pent1m_rom", 32'(pent1m_rom), 32'(exp_7ffd[4]));
		check_value("pent1m_1m_on", 32'(pent1m_1m_on), 32'(!exp_eff7[2]));
		check_value("pent1m_ram0_0", 32'(pent1m_ram0_0), 32'(exp_eff7[3]));
	endtask

	task automatic run_op(input int i);
		if (op_q[i] == "D")
		begin
			dos = data_q[i][0];
			@(negedge zclk);
		end
		else if (op_q[i] == "R" || op_q[i] == "W")
		begin
			bus_cycle(op_q[i] == "W", addr_q[i], data_q[i]);
			check_named(key_q[i], addr_q[i], exp_q[i]);
			if (op_q[i] == "W")
				follow_paging_write(addr_q[i], data_q[i]);
		end
		else
		begin
			errors++;
			$display("unknown operation %s in the trace", op_q[i]);
		end
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial
	begin
		logic [31:0] rnd;
		zclk          = 1'b0;
		rst_n         = 1'b0;
		a             = 16'h0000;
		din           = 8'h00;
		iorq_n        = 1'b1;
		rd_n          = 1'b1;
		wr_n          = 1'b1;
		dos           = 1'b0;
		kj_in         = 5'h15;
		sd_dataout    = 8'h5A;
		ramnroms      = 8'hC3;
		dos7ffds      = 8'h81;
		errors        = 0;
		n_checks      = 0;
		n_ops         = 0;
		trace_loaded  = 1'b0;
		exp_7ffd      = 8'h00; // reset state
		exp_eff7      = 8'h00;
		exp_shadow_en = 1'b0;
		rnd           = $urandom(32'h1922_65da); // seeds the generator too
		alu_in        = rnd[15:0];
		mus_in        = rnd[23:16];
		pages         = {$urandom, $urandom};
		load_trace();
		trace_loaded = 1'b1;
		repeat (2) @(negedge zclk);
		rst_n = 1'b1;
		if (n_ops == 0)
		begin
			errors++;
			$display("the trace holds no operations");
		end
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		$display("checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// 5 clocks per bus operation plus reset and slack
	initial
	begin
		wait (trace_loaded);
		#((n_ops * 5 + 20) * clk_period);
		$display("timeout: the trace did not finish in time");
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- sim/zports_trace.txt
# op addr data expected output; op R read, W write, D drives dos from data
# output rnd checks dout against the random alu_in, mus_in and pages inputs
R 00FE 00 00 rnd
R 00F6 00 00 rnd
R 001F 00 15 dout
R 00DF 00 00 rnd
R 0077 00 00 dout
R 0057 00 5A dout
R 0057 00 02 sd_start
R 0033 00 00 porthit
R 0033 00 FF dout
R FFFD 00 00 dataout
W 12FE 34 1234 alu_src
W ABF6 CD ABCD alu_arg
W 00BF 02 01 romrw_en
R 00BF 00 02 dout
W 7FFD 07 07 p7ffd
W FFFD 03 07 p7ffd
W EFF7 01 01 peff7
W 0077 00 00 sdcs_n
W 0057 A5 A5 sd_datain
W 0057 3C 02 sd_start
R 00BE 00 00 rnd
R 01BE 00 00 rnd
R 02BE 00 00 rnd
R 03BE 00 00 rnd
R 04BE 00 00 rnd
R 05BE 00 00 rnd
R 06BE 00 00 rnd
R 07BE 00 00 rnd
R 08BE 00 C3 dout
R 09BE 00 81 dout
R 0ABE 00 07 dout
R 0BBE 00 01 dout
W 00BF 01 00 romrw_en
R 001F 00 FF dout
R EEF7 00 01 porthit
W EEF7 55 01 peff7
W 8057 02 01 sdcs_n
W 00BF 00 00 romrw_en
D 0000 01 00 -
W EFF7 55 01 peff7
D 0000 00 00 -
W EFF7 04 00 peff7
W 7FFD E7 07 p7ffd
W 7FFD 01 07 p7ffd
R 0ABE 00 E7 dout
W 0033 00 3F pent1m_page

//--- list.f
+incdir+common
common/zports_pkg.sv
src/io_strobe.sv
src/port_decode.sv
paging/paging_regs.sv
src/sd_ctrl.sv
src/config_regs.sv
src/read_mux.sv
src/zports_top.sv
sim/zports_props.sv
sim/zports_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the port block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f list.f --top-module zports_tb -o zports_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/zports_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
